// ==== hdl/cpu_pkg.sv ====
// cpu instruction-level definitions for memory opcodes, exception codes and CP0 fields
`default_nettype none

package cpu_pkg;

  // register file address width
  localparam int REG_ADDR_W = 5;

  // memory operation, same encoding as the execute stage operation bus
  typedef enum logic [7:0] {
    NOP = 8'd0,
    LB  = 8'd1,
    LBU = 8'd2,
    LH  = 8'd3,
    LHU = 8'd4,
    LW  = 8'd5,
    SB  = 8'd6,
    SH  = 8'd7,
    SW  = 8'd8,
    LL  = 8'd9,
    SC  = 8'd10
  } mem_op_e;

  // final exception code handed to CP0
  typedef enum logic [4:0] {
    NONE = 5'd0,
    INT  = 5'd1,
    SYS  = 5'd8,
    BRK  = 5'd9,
    RI   = 5'd10,
    OV   = 5'd12,
    TRAP = 5'd13,
    ERET = 5'd14
  } exc_code_e;

  // bit positions in the raw exception word from execute
  localparam int EXC_SYS_BIT  = 7;
  localparam int EXC_RI_BIT   = 8;
  localparam int EXC_BRK_BIT  = 9;
  localparam int EXC_TRAP_BIT = 10;
  localparam int EXC_OV_BIT   = 11;
  localparam int EXC_ERET_BIT = 12;

  // Status fields
  localparam int STATUS_IE_BIT  = 0;
  localparam int STATUS_EXL_BIT = 1;

  // interrupt mask and pending fields, same place in Status and Cause
  localparam int IRQ_LSB = 8;
  localparam int IRQ_MSB = 15;

endpackage

`default_nettype wire

// ==== hdl/dmem_pkg.sv ====
// data memory bus definitions and the structs that travel through the memory stage
`default_nettype none

package dmem_pkg;

  // data and address width
  localparam int WORD_W = 32;
  // byte lanes per word
  localparam int LANES = 4;

  // request to the data memory
  typedef struct packed {
    logic [WORD_W-1:0] addr;
    logic [LANES-1:0]  sel;
    logic [WORD_W-1:0] wdata;
    logic              ce;
    logic              we;
    logic              re;
  } dmem_req_t;

  // instruction arriving from execute
  typedef struct packed {
    cpu_pkg::mem_op_e              op;
    logic [WORD_W-1:0]             addr;
    logic [WORD_W-1:0]             reg2;
    logic [cpu_pkg::REG_ADDR_W-1:0] wd;
    logic                          wreg;
  } ex_mem_t;

  // result toward write-back
  typedef struct packed {
    logic [cpu_pkg::REG_ADDR_W-1:0] wd;
    logic                          wreg;
    logic [WORD_W-1:0]             wdata;
  } wb_t;

endpackage

`default_nettype wire

// ==== hdl/except_select.sv ====
// exception selector: final exception code by fixed priority, interrupt first
`timescale 1ns/1ps
`default_nettype none

module except_select (
  input  wire [31:0]                     except_i,
  input  wire [31:0]                     pc_i,
  input  wire [31:0]                     cp0_status_i,
  input  wire [31:0]                     cp0_cause_i,
  output cpu_pkg::exc_code_e             exc_code_o,
  output logic                           exc_taken_o
);

  logic [cpu_pkg::IRQ_MSB:cpu_pkg::IRQ_LSB] irq_pending;
  logic                                     irq_take;

  // pending lines that Status leaves unmasked
  assign irq_pending = cp0_cause_i[cpu_pkg::IRQ_MSB:cpu_pkg::IRQ_LSB]
                     & cp0_status_i[cpu_pkg::IRQ_MSB:cpu_pkg::IRQ_LSB];

  // interrupts only outside exception level and with IE set
  assign irq_take = (|irq_pending)
                  & ~cp0_status_i[cpu_pkg::STATUS_EXL_BIT]
                  & cp0_status_i[cpu_pkg::STATUS_IE_BIT];

  always_comb
  begin
    exc_code_o = cpu_pkg::NONE;
    // a bubble carries pc 0 and never raises anything
    if (pc_i != '0)
    begin
      if (irq_take)
        exc_code_o = cpu_pkg::INT;
      else if (except_i[cpu_pkg::EXC_SYS_BIT])
        exc_code_o = cpu_pkg::SYS;
      else if (except_i[cpu_pkg::EXC_BRK_BIT])
        exc_code_o = cpu_pkg::BRK;
      else if (except_i[cpu_pkg::EXC_RI_BIT])
        exc_code_o = cpu_pkg::RI;
      else if (except_i[cpu_pkg::EXC_TRAP_BIT])
        exc_code_o = cpu_pkg::TRAP;
      else if (except_i[cpu_pkg::EXC_OV_BIT])
        exc_code_o = cpu_pkg::OV;
      else if (except_i[cpu_pkg::EXC_ERET_BIT])
        exc_code_o = cpu_pkg::ERET;
    end
  end

  assign exc_taken_o = (exc_code_o != cpu_pkg::NONE);

endmodule

`default_nettype wire

// ==== hdl/mem_req_gen.sv ====
// memory request builder: address, byte lanes, store data, enables and the stall request
`timescale 1ns/1ps
`default_nettype none

module mem_req_gen (
  input  wire cpu_pkg::mem_op_e          op_i,
  input  wire [dmem_pkg::WORD_W-1:0]     addr_i,
  input  wire [dmem_pkg::WORD_W-1:0]     reg2_i,
  input  wire                            link_i,
  input  wire                            exc_taken_i,
  input  wire                            rdata_valid_i,
  input  wire                            write_ready_i,
  output dmem_pkg::dmem_req_t            dmem_o,
  output logic                           stall_o
);

  logic [dmem_pkg::LANES-1:0]  lane_byte;
  logic [dmem_pkg::LANES-1:0]  lane_half;
  logic [dmem_pkg::LANES-1:0]  sel;
  logic [dmem_pkg::WORD_W-1:0] wdata;
  logic [dmem_pkg::WORD_W-1:0] addr;
  logic                        access;
  logic                        ce_raw;
  logic                        is_store;
  logic                        ce;
  logic                        we;
  logic                        re;

  // one-hot lane for a byte, lower or upper pair for a halfword
  assign lane_byte = {{(dmem_pkg::LANES-1){1'b0}}, 1'b1} << addr_i[1:0];
  assign lane_half = addr_i[1] ? 4'b1100 : 4'b0011;

  always_comb
  begin
    access   = 1'b1;
    ce_raw   = 1'b1;
    is_store = 1'b0;
    sel      = '0;
    wdata    = '0;
    case (op_i)
      cpu_pkg::LB, cpu_pkg::LBU:
      begin
        sel = lane_byte;
      end
      cpu_pkg::LH, cpu_pkg::LHU:
      begin
        // misaligned halfword load reads the whole word
        sel = addr_i[0] ? 4'b1111 : lane_half;
      end
      cpu_pkg::LW:
      begin
        sel = 4'b1111;
      end
      cpu_pkg::LL:
      begin
        sel   = 4'b1111;
        wdata = reg2_i;
      end
      cpu_pkg::SB:
      begin
        is_store = 1'b1;
        sel      = lane_byte;
        wdata    = {dmem_pkg::LANES{reg2_i[7:0]}};
      end
      cpu_pkg::SH:
      begin
        is_store = 1'b1;
        // misaligned halfword store writes no lane
        sel      = addr_i[0] ? 4'b0000 : lane_half;
        wdata    = {2{reg2_i[15:0]}};
      end
      cpu_pkg::SW:
      begin
        is_store = 1'b1;
        sel      = 4'b1111;
        wdata    = reg2_i;
      end
      cpu_pkg::SC:
      begin
        // store only goes out while the link holds
        ce_raw   = link_i;
        is_store = link_i;
        sel      = 4'b1111;
        wdata    = reg2_i;
      end
      default:
      begin
        access = 1'b0;
        ce_raw = 1'b0;
      end
    endcase
  end

  assign addr = access ? addr_i : '0;

  // an exception cancels the whole request
  assign ce = ce_raw & ~exc_taken_i;
  assign we = is_store & ~exc_taken_i;
  assign re = ce & ~we;

  assign dmem_o = '{addr: addr, sel: sel, wdata: wdata, ce: ce, we: we, re: re};

  // hold the pipeline until memory reports completion
  assign stall_o = (we & ~write_ready_i) | (re & ~rdata_valid_i);

endmodule

`default_nettype wire

// ==== hdl/load_align.sv ====
// load alignment: picks the addressed byte or half, extends it, and forms the SC result
`timescale 1ns/1ps
`default_nettype none

module load_align (
  input  wire dmem_pkg::ex_mem_t         ex_i,
  input  wire [dmem_pkg::WORD_W-1:0]     rdata_i,
  input  wire                            link_i,
  output dmem_pkg::wb_t                  wb_o
);

  logic [7:0]                  rbyte;
  logic [15:0]                 rhalf;
  logic                        half_misaligned;
  logic [dmem_pkg::WORD_W-1:0] wdata;

  // byte lane chosen by the low address bits
  assign rbyte = rdata_i[{ex_i.addr[1:0], 3'b000} +: 8];
  assign rhalf = ex_i.addr[1] ? rdata_i[31:16] : rdata_i[15:0];
  assign half_misaligned = ex_i.addr[0];

  always_comb
  begin
    wdata = '0;
    case (ex_i.op)
      cpu_pkg::LB:
      begin
        wdata = {{24{rbyte[7]}}, rbyte};
      end
      cpu_pkg::LBU:
      begin
        wdata = {24'd0, rbyte};
      end
      cpu_pkg::LH:
      begin
        if (!half_misaligned)
        begin
          wdata = {{16{rhalf[15]}}, rhalf};
        end
      end
      cpu_pkg::LHU:
      begin
        if (!half_misaligned)
        begin
          wdata = {16'd0, rhalf};
        end
      end
      cpu_pkg::LW, cpu_pkg::LL:
      begin
        wdata = rdata_i;
      end
      cpu_pkg::SC:
      begin
        // success flag written back to rt
        wdata = {{(dmem_pkg::WORD_W-1){1'b0}}, link_i};
      end
      default:
      begin
        wdata = '0;
      end
    endcase
  end

  assign wb_o = '{wd: ex_i.wd, wreg: ex_i.wreg, wdata: wdata};

endmodule

`default_nettype wire

// ==== hdl/llbit_reg.sv ====
// LL/SC link bit, set by LL and cleared by SC or an exception
`timescale 1ns/1ps
`default_nettype none

module llbit_reg (
  input  wire                            clk,
  input  wire                            rst_n_i,
  input  wire cpu_pkg::mem_op_e          op_i,
  input  wire                            exc_taken_i,
  input  wire                            stall_i,
  output logic                           link_o
);

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      link_o <= 1'b0;
    end
    // only commit once the access has completed
    else if (!stall_i)
    begin
      if (exc_taken_i)
        link_o <= 1'b0;
      else if (op_i == cpu_pkg::LL)
        link_o <= 1'b1;
      else if (op_i == cpu_pkg::SC)
        link_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mem_stage.sv ====
// memory access stage top: exception select, request build, load align and link bit
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  wire                            clk,
  input  wire                            rst_n_i,
  input  wire dmem_pkg::ex_mem_t         ex_i,
  input  wire [31:0]                     except_i,
  input  wire [31:0]                     pc_i,
  input  wire [31:0]                     cp0_status_i,
  input  wire [31:0]                     cp0_cause_i,
  input  wire [dmem_pkg::WORD_W-1:0]     rdata_i,
  input  wire                            rdata_valid_i,
  input  wire                            write_ready_i,
  output dmem_pkg::dmem_req_t            dmem_o,
  output dmem_pkg::wb_t                  wb_o,
  output cpu_pkg::exc_code_e             exc_code_o,
  output logic                           stall_o
);

  logic exc_taken;
  logic link;

  except_select u_except (
    .except_i     (except_i),
    .pc_i         (pc_i),
    .cp0_status_i (cp0_status_i),
    .cp0_cause_i  (cp0_cause_i),
    .exc_code_o   (exc_code_o),
    .exc_taken_o  (exc_taken)
  );

  mem_req_gen u_req (
    .op_i          (ex_i.op),
    .addr_i        (ex_i.addr),
    .reg2_i        (ex_i.reg2),
    .link_i        (link),
    .exc_taken_i   (exc_taken),
    .rdata_valid_i (rdata_valid_i),
    .write_ready_i (write_ready_i),
    .dmem_o        (dmem_o),
    .stall_o       (stall_o)
  );

  load_align u_load (
    .ex_i    (ex_i),
    .rdata_i (rdata_i),
    .link_i  (link),
    .wb_o    (wb_o)
  );

  // link bit holds while the stage is stalled
  llbit_reg u_llbit (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .op_i        (ex_i.op),
    .exc_taken_i (exc_taken),
    .stall_i     (stall_o),
    .link_o      (link)
  );

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
// testbench clock and reset source, 4 ns clock with reset low for 3 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 3;

  initial
  begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release lands 1 ns after the last reset edge, like the stimulus
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/mem_stage_chk.sv ====
// bound checker for request enables, exception cancel and link bit stability
`timescale 1ns/1ps
`default_nettype none

module mem_stage_chk (
  input  wire                      clk_i,
  input  wire                      rst_n_i,
  input  wire dmem_pkg::dmem_req_t dmem_i,
  input  wire                      exc_taken_i,
  input  wire                      link_i,
  input  wire                      stall_i
);

  // read and write are exclusive
  a_we_re_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(dmem_i.we && dmem_i.re))
    else $error("dmem we and re set together");

  a_en_needs_ce: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (dmem_i.we || dmem_i.re) |-> dmem_i.ce)
    else $error("dmem we or re set without ce");

  // a taken exception cancels the access
  a_exc_no_ce: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exc_taken_i |-> !dmem_i.ce)
    else $error("dmem ce set while an exception is taken");

  a_link_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_i |=> $stable(link_i))
    else $error("link bit changed across a stalled edge");

endmodule

bind mem_stage mem_stage_chk u_chk (
  .clk_i       (clk),
  .rst_n_i     (rst_n_i),
  .dmem_i      (dmem_o),
  .exc_taken_i (exc_taken),
  .link_i      (link),
  .stall_i     (stall_o)
);

`default_nettype wire

// ==== test/tb_mem_stage.sv ====
// testbench top for the memory stage, stimulus and expected values from a vector file
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

  localparam int RESET_TIMEOUT = 20;
  localparam int MAX_LINES     = 1000;
  localparam int WATCHDOG_NS   = 100000;

  logic                clk;
  logic                rst_n;
  dmem_pkg::ex_mem_t   ex;
  logic [31:0]         except_w;
  logic [31:0]         pc;
  logic [31:0]         cp0_status;
  logic [31:0]         cp0_cause;
  logic [31:0]         rdata;
  logic                rdata_valid;
  logic                write_ready;
  dmem_pkg::dmem_req_t dmem;
  dmem_pkg::wb_t       wb;
  cpu_pkg::exc_code_e  exc_code;
  logic                stall;

  tb_clk_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mem_stage u_dut (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .ex_i          (ex),
    .except_i      (except_w),
    .pc_i          (pc),
    .cp0_status_i  (cp0_status),
    .cp0_cause_i   (cp0_cause),
    .rdata_i       (rdata),
    .rdata_valid_i (rdata_valid),
    .write_ready_i (write_ready),
    .dmem_o        (dmem),
    .wb_o          (wb),
    .exc_code_o    (exc_code),
    .stall_o       (stall)
  );

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // hs packs rdata_valid in bit 1 and write_ready in bit 0
  task automatic apply_inputs(input logic [31:0] op, addr, reg2, exc, pc_v, st, ca, rd, hs);
    ex.op       = cpu_pkg::mem_op_e'(op[7:0]);
    ex.addr     = addr;
    ex.reg2     = reg2;
    // destination fields only pass through, so vary them with the address
    ex.wd       = addr[4:0];
    ex.wreg     = ~addr[0];
    except_w    = exc;
    pc          = pc_v;
    cp0_status  = st;
    cp0_cause   = ca;
    rdata       = rd;
    rdata_valid = hs[1];
    write_ready = hs[0];
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    fail_now("timeout: the vector run did not finish in time");
  end

  initial
  begin
    int          fd;
    int          got_chars;
    int          n_fields;
    int          line_no;
    int          vec_count;
    int          wait_cycles;
    string       line;
    logic [31:0] f_op, f_addr, f_reg2, f_exc, f_pc, f_st, f_ca, f_rdata, f_hs;
    logic [31:0] e_addr, e_sel, e_wdata, e_ctl, e_wb, e_exc, e_stall;

    apply_inputs('0, '0, '0, '0, '0, '0, '0, '0, '0);

    wait_cycles = 0;
    while (rst_n !== 1'b1)
    begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > RESET_TIMEOUT)
        fail_now("timeout: reset was never released");
    end

    fd = $fopen("test/mem_stage_vectors.txt", "r");
    if (fd == 0)
      fail_now("could not open test/mem_stage_vectors.txt");

    line_no   = 0;
    vec_count = 0;
    while (!$feof(fd) && line_no < MAX_LINES)
    begin
      line      = "";
      got_chars = $fgets(line, fd);
      line_no++;
      // skip comments and blank lines
      if (got_chars < 2 || line.getc(0) == "#")
        continue;
      n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         f_op, f_addr, f_reg2, f_exc, f_pc, f_st, f_ca, f_rdata, f_hs,
                         e_addr, e_sel, e_wdata, e_ctl, e_wb, e_exc, e_stall);
      if (n_fields != 16)
        fail_now($sformatf("vector line %0d does not hold 16 fields", line_no));

      @(posedge clk);
      #1;
      apply_inputs(f_op, f_addr, f_reg2, f_exc, f_pc, f_st, f_ca, f_rdata, f_hs);
      // outputs settle well before the next edge
      #2;
      check_val("dmem_o.addr", dmem.addr, e_addr);
      check_val("dmem_o.sel", {28'd0, dmem.sel}, e_sel);
      check_val("dmem_o.wdata", dmem.wdata, e_wdata);
      check_val("dmem_o.ce", {31'd0, dmem.ce}, {31'd0, e_ctl[2]});
      check_val("dmem_o.we", {31'd0, dmem.we}, {31'd0, e_ctl[1]});
      check_val("dmem_o.re", {31'd0, dmem.re}, {31'd0, e_ctl[0]});
      check_val("wb_o.wdata", wb.wdata, e_wb);
      check_val("wb_o.wd", {27'd0, wb.wd}, {27'd0, f_addr[4:0]});
      check_val("wb_o.wreg", {31'd0, wb.wreg}, {31'd0, ~f_addr[0]});
      check_val("exc_code_o", {27'd0, exc_code}, e_exc);
      check_val("stall_o", {31'd0, stall}, e_stall);
      vec_count++;
    end
    $fclose(fd);

    if (vec_count == 0)
    begin
      fail_now("no vectors were read from the vector file");
    end
    else
    begin
      $display("%0d vectors checked", vec_count);
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== mem_stage.f ====
hdl/cpu_pkg.sv
hdl/dmem_pkg.sv
hdl/except_select.sv
hdl/mem_req_gen.sv
hdl/load_align.sv
hdl/llbit_reg.sv
hdl/mem_stage.sv
test/tb_clk_gen.sv
test/mem_stage_chk.sv
test/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the memory stage testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_mem_stage \
  -f mem_stage.f > build.log 2>&1 \
  && ./obj_dir/Vtb_mem_stage > sim.log 2>&1 \
  || echo "=== FAIL ===" >> sim.log

cat build.log sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0

// ==== test/mem_stage_vectors.txt ====
# op addr reg2 except pc status cause rdata hs(rvalid,wready), then expected:
# addr sel wdata ctl(ce,we,re) wb_wdata exc_code stall
01 00001000 00000000 0000 0100 0000 0000 80f17f82 3 00001000 1 00000000 5 ffffff82 00 0
01 00001001 00000000 0000 0100 0000 0000 80f17f82 3 00001001 2 00000000 5 0000007f 00 0
01 00001002 00000000 0000 0100 0000 0000 80f17f82 3 00001002 4 00000000 5 fffffff1 00 0
01 00001003 00000000 0000 0100 0000 0000 80f17f82 3 00001003 8 00000000 5 ffffff80 00 0
02 00001000 00000000 0000 0100 0000 0000 80f17f82 3 00001000 1 00000000 5 00000082 00 0
03 00001000 00000000 0000 0100 0000 0000 80f17f82 3 00001000 3 00000000 5 00007f82 00 0
03 00001002 00000000 0000 0100 0000 0000 80f17f82 3 00001002 c 00000000 5 ffff80f1 00 0
04 00001002 00000000 0000 0100 0000 0000 80f17f82 3 00001002 c 00000000 5 000080f1 00 0
04 00001001 00000000 0000 0100 0000 0000 80f17f82 3 00001001 f 00000000 5 00000000 00 0
05 00001004 00000000 0000 0100 0000 0000 80f17f82 3 00001004 f 00000000 5 80f17f82 00 0
06 00002001 12345678 0000 0100 0000 0000 80f17f82 3 00002001 2 78787878 6 00000000 00 0
07 00002002 12345678 0000 0100 0000 0000 80f17f82 3 00002002 c 56785678 6 00000000 00 0
07 00002001 12345678 0000 0100 0000 0000 80f17f82 3 00002001 0 56785678 6 00000000 00 0
08 00002000 12345678 0000 0100 0000 0000 80f17f82 3 00002000 f 12345678 6 00000000 00 0
09 00003000 12345678 0000 0100 0000 0000 80f17f82 3 00003000 f 12345678 5 80f17f82 00 0
0a 00003000 cafef00d 0000 0100 0000 0000 80f17f82 3 00003000 f cafef00d 6 00000001 00 0
0a 00003000 cafef00d 0000 0100 0000 0000 80f17f82 3 00003000 f cafef00d 0 00000000 00 0
05 00004000 00000000 1f80 0100 ff01 0400 80f17f82 3 00004000 f 00000000 0 80f17f82 01 0
05 00004000 00000000 1f80 0100 ff03 0400 80f17f82 3 00004000 f 00000000 0 80f17f82 08 0
05 00004000 00000000 1e00 0100 0000 0000 80f17f82 3 00004000 f 00000000 0 80f17f82 09 0
05 00004000 00000000 1c00 0100 0000 0000 80f17f82 3 00004000 f 00000000 0 80f17f82 0d 0
05 00004000 00000000 1f80 0000 ff01 ff00 80f17f82 3 00004000 f 00000000 5 80f17f82 00 0
08 00004000 12345678 0080 0100 0000 0000 80f17f82 3 00004000 f 12345678 0 00000000 08 0
08 00005000 11223344 0000 0100 0000 0000 80f17f82 2 00005000 f 11223344 6 00000000 00 1
08 00005000 11223344 0000 0100 0000 0000 80f17f82 3 00005000 f 11223344 6 00000000 00 0
05 00005000 00000000 0000 0100 0000 0000 80f17f82 1 00005000 f 00000000 5 80f17f82 00 1
05 00005000 00000000 0000 0100 0000 0000 80f17f82 3 00005000 f 00000000 5 80f17f82 00 0
09 00006000 00000000 0000 0100 0000 0000 80f17f82 1 00006000 f 00000000 5 80f17f82 00 1
09 00006000 00000000 0000 0100 0000 0000 80f17f82 1 00006000 f 00000000 5 80f17f82 00 1
09 00006000 00000000 0000 0100 0000 0000 80f17f82 3 00006000 f 00000000 5 80f17f82 00 0
0a 00006000 55aa55aa 0000 0100 0000 0000 80f17f82 2 00006000 f 55aa55aa 6 00000001 00 1
0a 00006000 55aa55aa 0000 0100 0000 0000 80f17f82 3 00006000 f 55aa55aa 6 00000001 00 0
0a 00006000 55aa55aa 0000 0100 0000 0000 80f17f82 3 00006000 f 55aa55aa 0 00000000 00 0
00 00000000 00000000 0000 0100 0000 0000 80f17f82 3 00000000 0 00000000 0 00000000 00 0
